/* hdl/masku_cfg_pkg.sv */
// Geometry of the mask unit is fixed at two 64-bit lanes and 512-bit registers and changes only here
`default_nettype none

package masku_cfg_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // Lanes side by side in one beat
  localparam int unsigned NrLanes = 2;
  // Width of one lane word
  localparam int unsigned ElenBits = 64;
  // One beat spans every lane
  localparam int unsigned BeatBits = NrLanes * ElenBits;
  // Bits held by one vector register
  localparam int unsigned VlenBits = 512;
  // Lane words per register in each lane
  localparam int unsigned BeatsPerReg = VlenBits / BeatBits;
  // Entries in the write-back queue
  localparam int unsigned ResultQueueDepth = 2;
  // Instruction ids handed out by the sequencer
  localparam int unsigned NrVInsn = 8;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  typedef logic [ElenBits-1:0] elen_t;
  // Vector length in bits, legal range 1 to VlenBits
  typedef logic [$clog2(VlenBits):0] vl_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0] vreg_t;
  // Lane word address, register number times BeatsPerReg plus beat
  typedef logic [6:0] vaddr_t;
  // Beat count, must reach BeatsPerReg itself
  typedef logic [$clog2(BeatsPerReg):0] beat_cnt_t;

endpackage

`default_nettype wire

/* hdl/masku_if_pkg.sv */
// Bundles at the mask unit boundary and between its stages, built on the fixed two-lane geometry
`default_nettype none

package masku_if_pkg;

  import masku_cfg_pkg::*;

  //////////////////////////////
  // Sequencer side
  //////////////////////////////

  // One mask-logical instruction
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    // High when the instruction is unmasked
    logic  vm;
  } masku_req_t;

  // One done bit per instruction id
  typedef struct packed {
    logic [NrVInsn-1:0] vinsn_done;
  } masku_resp_t;

  //////////////////////////////
  // Lane side
  //////////////////////////////

  // Operands of one lane for one beat
  typedef struct packed {
    // Result of the operation
    elen_t a;
    // Old value of the destination
    elen_t b;
    // Mask bits, ignored when unmasked
    elen_t m;
  } lane_operands_t;

  // Write-back word for one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
  } result_entry_t;

  // Held instruction plus the beat being issued
  typedef struct packed {
    vid_t      id;
    vreg_t     vd;
    vl_t       vl;
    logic      vm;
    beat_cnt_t beat;
  } beat_info_t;

endpackage

`default_nettype wire

/* hdl/masku_insn_ctrl.sv */
// Holds one instruction at a time and expects vl between 1 and VlenBits from the sequencer
`timescale 1ns/1ns
`default_nettype none

module masku_insn_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sequencer
  input  masku_if_pkg::masku_req_t  pe_req_i,
  input  logic                      pe_req_valid_i,
  output logic                      pe_req_ready_o,
  output masku_if_pkg::masku_resp_t pe_resp_o,
  // Toward the merge ALU
  output masku_if_pkg::beat_info_t  beat_info_o,
  output logic                      issue_ok_o,
  input  logic                      issue_fire_i,
  // From the result queue
  input  logic                      pop_i
);

  import masku_cfg_pkg::*;
  import masku_if_pkg::*;

  typedef enum logic {
    st_idle,
    st_busy
  } state_e;

  state_e      state_d, state_q;
  masku_req_t  insn_q;
  // Beats still to issue and still to write back
  beat_cnt_t   issue_cnt_d, issue_cnt_q;
  beat_cnt_t   commit_cnt_d, commit_cnt_q;
  masku_resp_t resp_d;
  logic        accept;

  // vl rounded up to whole beats
  function automatic beat_cnt_t num_beats(input vl_t vl);
    return beat_cnt_t'((vl + BeatBits - 1) / BeatBits);
  endfunction

  //////////////////////////////
  // Sequencer handshake
  //////////////////////////////

  assign pe_req_ready_o = (state_q == st_idle);
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Beats left to issue
  assign issue_ok_o = (state_q == st_busy) && (issue_cnt_q != '0);

  // Beat index counts up as issue_cnt counts down
  assign beat_info_o.id   = insn_q.id;
  assign beat_info_o.vd   = insn_q.vd;
  assign beat_info_o.vl   = insn_q.vl;
  assign beat_info_o.vm   = insn_q.vm;
  assign beat_info_o.beat = num_beats(insn_q.vl) - issue_cnt_q;

  //////////////////////////////
  // Counters and done
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    resp_d       = '0;

    if (issue_fire_i) begin
      issue_cnt_d = issue_cnt_q - beat_cnt_t'(1);
    end

    if (pop_i) begin
      commit_cnt_d = commit_cnt_q - beat_cnt_t'(1);
      // Last beat written back, release and flag done next cycle
      if (commit_cnt_q == beat_cnt_t'(1)) begin
        state_d                       = st_idle;
        resp_d.vinsn_done[insn_q.id] = 1'b1;
      end
    end

    // Only possible while idle, so no counter activity collides
    if (accept) begin
      state_d      = st_busy;
      issue_cnt_d  = num_beats(pe_req_i.vl);
      commit_cnt_d = num_beats(pe_req_i.vl);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_idle;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      pe_resp_o    <= '0;
    end else begin
      state_q      <= state_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      pe_resp_o    <= resp_d;
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Queue pops only beats this instruction pushed
  a_pop_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (commit_cnt_q != '0));

  // Sequencer sends legal vector lengths
  a_vl_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (pe_req_i.vl != '0) && (pe_req_i.vl <= VlenBits));

endmodule

`default_nettype wire

/* hdl/masku_merge_alu.sv */
// Linear bit layout with no element-width shuffle and only the mask-logical merge
`timescale 1ns/1ns
`default_nettype none

module masku_merge_alu (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // From instruction control
  input  masku_if_pkg::beat_info_t                                 beat_info_i,
  input  logic                                                     issue_ok_i,
  output logic                                                     issue_fire_o,
  // Lane operands
  input  masku_if_pkg::lane_operands_t [masku_cfg_pkg::NrLanes-1:0] operand_i,
  input  logic [masku_cfg_pkg::NrLanes-1:0]                         operand_valid_i,
  output logic [masku_cfg_pkg::NrLanes-1:0]                         operand_ready_o,
  // Toward the result queue
  input  logic                                                     queue_full_i,
  output logic                                                     push_o,
  output masku_if_pkg::result_entry_t [masku_cfg_pkg::NrLanes-1:0]  entry_o
);

  import masku_cfg_pkg::*;
  import masku_if_pkg::*;

  logic                      fire;
  // First vector bit index of this beat
  logic [$bits(vl_t):0]      bit_base;
  logic [BeatBits-1:0]       vl_enable;
  logic [BeatBits-1:0]       mask_flat;
  logic [BeatBits-1:0]       bit_enable;
  vaddr_t                    beat_addr;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // All lanes at once, and only with room to store the beat
  assign fire            = issue_ok_i && (&operand_valid_i) && !queue_full_i;
  assign operand_ready_o = {NrLanes{fire}};
  assign issue_fire_o    = fire;
  assign push_o          = fire;

  //////////////////////////////
  // Bit enable
  //////////////////////////////

  assign bit_base = ($bits(vl_t) + 1)'(beat_info_i.beat * BeatBits);

  // Bits below vl take the new value
  always_comb begin
    for (int i = 0; i < BeatBits; i++) begin
      vl_enable[i] = (bit_base + i) < beat_info_i.vl;
    end
  end

  // Lane 0 holds the low word of the beat
  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_mask_flat
    assign mask_flat[lane*ElenBits +: ElenBits] = operand_i[lane].m;
  end

  // Masked instructions also need their mask bit set
  assign bit_enable = beat_info_i.vm ? vl_enable : (vl_enable & mask_flat);

  //////////////////////////////
  // Merge and address
  //////////////////////////////

  assign beat_addr = vaddr_t'(beat_info_i.vd) * vaddr_t'(BeatsPerReg) +
                     vaddr_t'(beat_info_i.beat);

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_merge
    elen_t lane_en;

    assign lane_en = bit_enable[lane*ElenBits +: ElenBits];

    // Same word address in every lane
    assign entry_o[lane].id    = beat_info_i.id;
    assign entry_o[lane].addr  = beat_addr;
    assign entry_o[lane].wdata = (operand_i[lane].a & lane_en) |
                                 (operand_i[lane].b & ~lane_en);

    // Lanes hold their operands until the beat is taken
    a_operand_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (operand_valid_i[lane] && !operand_ready_o[lane]) |=>
        (operand_valid_i[lane] && $stable(operand_i[lane])));
  end

endmodule

`default_nettype wire

/* hdl/masku_result_queue.sv */
// Two-entry write-back queue where an entry leaves only after every lane has granted it
`timescale 1ns/1ns
`default_nettype none

module masku_result_queue (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // From the merge ALU
  input  logic                                                     push_i,
  input  masku_if_pkg::result_entry_t [masku_cfg_pkg::NrLanes-1:0]  entry_i,
  output logic                                                     full_o,
  // To instruction control
  output logic                                                     pop_o,
  // Lane write-back
  output logic [masku_cfg_pkg::NrLanes-1:0]                         result_req_o,
  output masku_if_pkg::result_entry_t [masku_cfg_pkg::NrLanes-1:0]  result_o,
  input  logic [masku_cfg_pkg::NrLanes-1:0]                         result_gnt_i
);

  import masku_cfg_pkg::*;
  import masku_if_pkg::*;

  result_entry_t [ResultQueueDepth-1:0][NrLanes-1:0] data_q;
  // Per-lane pending bits of each entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0]          valid_d, valid_q;
  logic [$clog2(ResultQueueDepth)-1:0]               wr_ptr_d, wr_ptr_q;
  logic [$clog2(ResultQueueDepth)-1:0]               rd_ptr_d, rd_ptr_q;
  logic [$clog2(ResultQueueDepth):0]                 cnt_d, cnt_q;

  assign full_o = (cnt_q == ResultQueueDepth);

  // Head entry drives the lanes
  assign result_req_o = valid_q[rd_ptr_q];
  assign result_o     = data_q[rd_ptr_q];

  //////////////////////////////
  // Queue control
  //////////////////////////////

  always_comb begin
    valid_d  = valid_q;
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;
    cnt_d    = cnt_q;

    // Granted lanes drop their request next cycle
    for (int lane = 0; lane < NrLanes; lane++) begin
      if (result_req_o[lane] && result_gnt_i[lane]) begin
        valid_d[rd_ptr_q][lane] = 1'b0;
      end
    end

    // Head done once no lane is left pending
    pop_o = (cnt_q != '0) && (valid_d[rd_ptr_q] == '0);
    if (pop_o) begin
      rd_ptr_d = (rd_ptr_q == ResultQueueDepth - 1) ? '0 : rd_ptr_q + 1'b1;
    end

    // New entry requests on every lane
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
      wr_ptr_d          = (wr_ptr_q == ResultQueueDepth - 1) ? '0 : wr_ptr_q + 1'b1;
    end

    if (push_i && !pop_o) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!push_i && pop_o) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_ptr_q] <= entry_i;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // ALU holds off while the queue is full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // Lanes grant only what is requested
  a_gnt_has_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

endmodule

`default_nettype wire

/* hdl/masku_top.sv */
// Two-lane mask unit for mask-logical instructions only, one instruction in flight at a time
`timescale 1ns/1ns
`default_nettype none

module masku_top (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // Sequencer
  input  masku_if_pkg::masku_req_t                                 pe_req_i,
  input  logic                                                     pe_req_valid_i,
  output logic                                                     pe_req_ready_o,
  output masku_if_pkg::masku_resp_t                                pe_resp_o,
  // Lane operands
  input  masku_if_pkg::lane_operands_t [masku_cfg_pkg::NrLanes-1:0] operand_i,
  input  logic [masku_cfg_pkg::NrLanes-1:0]                         operand_valid_i,
  output logic [masku_cfg_pkg::NrLanes-1:0]                         operand_ready_o,
  // Lane write-back
  output logic [masku_cfg_pkg::NrLanes-1:0]                         result_req_o,
  output masku_if_pkg::result_entry_t [masku_cfg_pkg::NrLanes-1:0]  result_o,
  input  logic [masku_cfg_pkg::NrLanes-1:0]                         result_gnt_i
);

  import masku_cfg_pkg::*;
  import masku_if_pkg::*;

  beat_info_t                  beat_info;
  logic                        issue_ok;
  logic                        issue_fire;
  logic                        push;
  logic                        queue_full;
  logic                        pop;
  result_entry_t [NrLanes-1:0] entry;

  // Instruction hold, beat counters and done pulse
  masku_insn_ctrl u_insn_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .pe_resp_o      (pe_resp_o),
    .beat_info_o    (beat_info),
    .issue_ok_o     (issue_ok),
    .issue_fire_i   (issue_fire),
    .pop_i          (pop)
  );

  // Per-beat merge of a and b
  masku_merge_alu u_merge_alu (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .beat_info_i     (beat_info),
    .issue_ok_i      (issue_ok),
    .issue_fire_o    (issue_fire),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .queue_full_i    (queue_full),
    .push_o          (push),
    .entry_o         (entry)
  );

  // Write-back toward the lanes
  masku_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .entry_i      (entry),
    .full_o       (queue_full),
    .pop_o        (pop),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_masku \
  -o sim_masku > build.log 2>&1 \
  && ./obj_dir/sim_masku > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+sim
hdl/masku_cfg_pkg.sv
hdl/masku_if_pkg.sv
hdl/masku_insn_ctrl.sv
hdl/masku_merge_alu.sv
hdl/masku_result_queue.sv
hdl/masku_top.sv
sim/tb_masku.sv

/* sim/tb_masku_checks.svh */
// Reference merge and compare tasks, included in the testbench module body after its package imports
`ifndef TB_MASKU_CHECKS_SVH
`define TB_MASKU_CHECKS_SVH

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Vector bit index is beat*128 + lane*64 + bit
  // A bit takes a below vl when unmasked or its mask bit is set, else it keeps b
  function automatic elen_t merge_ref(input lane_operands_t op, input vl_t vl, input logic vm,
                                      input int beat, input int lane);
    elen_t res;
    int    idx;
    for (int i = 0; i < ElenBits; i++) begin
      idx    = beat * int'(BeatBits) + lane * int'(ElenBits) + i;
      res[i] = ((idx < int'(vl)) && (vm || op.m[i])) ? op.a[i] : op.b[i];
    end
    return res;
  endfunction

  // Word address is vd*4 plus the beat
  function automatic result_entry_t expected_entry(input masku_req_t req, input lane_operands_t op,
                                                   input int beat, input int lane);
    result_entry_t e;
    e.id    = req.id;
    e.addr  = vaddr_t'(int'(req.vd) * int'(BeatsPerReg) + beat);
    e.wdata = merge_ref(op, req.vl, req.vm, beat, lane);
    return e;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic report_failure(input string msg);
    errors++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  task automatic check_entry(input result_entry_t got, input result_entry_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got id %0d addr %0d data %h", $time, what,
               got.id, got.addr, got.wdata);
      $display("  expected id %0d addr %0d data %h", exp.id, exp.addr, exp.wdata);
    end
  endtask

  task automatic check_done(input masku_resp_t got, input masku_resp_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %b expected %b", $time, what,
               got.vinsn_done, exp.vinsn_done);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
    end
  endtask

`endif

/* sim/tb_masku.sv */
// Directed tests for the two-lane mask unit, inputs driven on the falling edge, one instruction at a time
`timescale 1ns/1ns
`default_nettype none

module tb_masku;

  import masku_cfg_pkg::*;
  import masku_if_pkg::*;

  //////////////////////////////
  // Run limits
  //////////////////////////////

  localparam int ClkPeriodNs = 40;
  // Combinational outputs have settled this long after the falling edge
  localparam int SettleNs = 5;
  // Five tests of about 100 cycles with stalls, four times that as margin
  localparam int TimeoutCycles = 2000;

  logic                         clk;
  logic                         rst_n;
  masku_req_t                   pe_req;
  logic                         pe_req_valid;
  logic                         pe_req_ready;
  masku_resp_t                  pe_resp;
  lane_operands_t [NrLanes-1:0] operand;
  logic [NrLanes-1:0]           operand_valid;
  logic [NrLanes-1:0]           operand_ready;
  logic [NrLanes-1:0]           result_req;
  result_entry_t [NrLanes-1:0]  result;
  logic [NrLanes-1:0]           result_gnt;

  // Lanes whose grant is withheld
  logic [NrLanes-1:0]          gnt_block;
  logic [15:0]                 lfsr_q;
  int                          cycles = 0;
  int                          checks = 0;
  int                          errors = 0;
  // Expected beats in acceptance order over the whole run
  result_entry_t [NrLanes-1:0] exp_q[$];
  // Words granted so far on each lane
  int                          lane_cnt[NrLanes];
  logic [NrLanes-1:0]          prev_req;
  logic [NrLanes-1:0]          prev_gnt;
  result_entry_t [NrLanes-1:0] prev_result;

  `include "tb_masku_checks.svh"

  masku_top u_masku_top (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .pe_req_i        (pe_req),
    .pe_req_valid_i  (pe_req_valid),
    .pe_req_ready_o  (pe_req_ready),
    .pe_resp_o       (pe_resp),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_o        (result),
    .result_gnt_i    (result_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriodNs / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the run was still busy after %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Random data
  //////////////////////////////

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic elen_t rand_word();
    elen_t w;
    w = '0;
    for (int i = 0; i < ElenBits; i++) begin
      w = {w[ElenBits-2:0], lfsr_bit()};
    end
    return w;
  endfunction

  //////////////////////////////
  // Write-back lanes
  //////////////////////////////

  // Grant what is requested unless blocked, check each granted word in order
  initial begin
    prev_req    = '0;
    prev_gnt    = '0;
    prev_result = '0;
    foreach (lane_cnt[l]) lane_cnt[l] = 0;
    forever begin
      @(negedge clk);
      result_gnt = result_req & ~gnt_block;
      for (int l = 0; l < NrLanes; l++) begin
        // An ungranted request keeps its word
        if (prev_req[l] && !prev_gnt[l]) begin
          check_flag(result_req[l], 1'b1, "request held until granted");
          check_entry(result[l], prev_result[l], "word held until granted");
        end
        if (result_req[l] && result_gnt[l]) begin
          if (lane_cnt[l] < exp_q.size()) begin
            check_entry(result[l], exp_q[lane_cnt[l]][l], "granted word");
          end else begin
            report_failure("a lane requested a word although no beat was accepted for it");
          end
          lane_cnt[l]++;
        end
      end
      prev_req    = result_req;
      prev_gnt    = result_gnt;
      prev_result = result;
    end
  end

  //////////////////////////////
  // Sequencer and operands
  //////////////////////////////

  // Offer random beats and record the expected words of each accepted one
  task automatic feed_beats(input masku_req_t req, input int nbeats);
    result_entry_t [NrLanes-1:0] exp;
    int                          completed;
    int                          lane_done;
    for (int beat = 0; beat < nbeats; beat++) begin
      @(negedge clk);
      for (int l = 0; l < NrLanes; l++) begin
        operand[l].a = rand_word();
        operand[l].b = rand_word();
        operand[l].m = rand_word();
        exp[l]       = expected_entry(req, operand[l], beat, l);
      end
      operand_valid = '1;
      #SettleNs;
      while (operand_ready != '1) begin
        @(negedge clk);
        #SettleNs;
      end
      // Beats fully granted before the coming edge, which pops only later
      completed = lane_cnt[0] - int'(result_req[0] && result_gnt[0]);
      for (int l = 1; l < NrLanes; l++) begin
        lane_done = lane_cnt[l] - int'(result_req[l] && result_gnt[l]);
        if (lane_done < completed) completed = lane_done;
      end
      check_flag((exp_q.size() - completed) < ResultQueueDepth, 1'b1,
                 "beat taken with room in the queue");
      exp_q.push_back(exp);
    end
    @(negedge clk);
    operand_valid = '0;
  endtask

  task automatic wait_done(input masku_resp_t exp_resp, input int first, input int nbeats);
    while (pe_resp == '0) begin
      @(negedge clk);
    end
    check_done(pe_resp, exp_resp, "done pulse");
    check_flag(pe_req_ready, 1'b1, "ready rises with done");
    for (int l = 0; l < NrLanes; l++) begin
      check_flag(lane_cnt[l] == first + nbeats, 1'b1, "every word granted before done");
    end
    @(negedge clk);
    check_done(pe_resp, '0, "done lasts one cycle");
  endtask

  task automatic run_insn(input masku_req_t req);
    int          nbeats;
    int          first;
    masku_resp_t exp_resp;
    // vl rounded up to whole beats
    nbeats   = (int'(req.vl) + int'(BeatBits) - 1) / int'(BeatBits);
    first    = exp_q.size();
    exp_resp = '0;
    exp_resp.vinsn_done[req.id] = 1'b1;
    @(negedge clk);
    check_flag(pe_req_ready, 1'b1, "ready while idle");
    pe_req       = req;
    pe_req_valid = 1'b1;
    @(negedge clk);
    pe_req_valid = 1'b0;
    check_flag(pe_req_ready, 1'b0, "ready low while holding");
    fork
      feed_beats(req, nbeats);
      wait_done(exp_resp, first, nbeats);
    join
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check_flag(pe_req_ready, 1'b1, "ready after reset");
    check_flag(result_req == '0, 1'b1, "no request after reset");
    check_flag(operand_ready == '0, 1'b1, "no operand ready after reset");
    check_done(pe_resp, '0, "no done after reset");
  endtask

  // Every bit enabled, so each word is a and addresses run vd*4 to vd*4+3
  task automatic test_full_unmasked();
    run_insn('{id: 3'd1, vd: 5'd3, vl: 10'd512, vm: 1'b1});
  endtask

  // One beat, bits 100 and up keep b
  task automatic test_short_vl();
    run_insn('{id: 3'd2, vd: 5'd5, vl: 10'd100, vm: 1'b1});
  endtask

  task automatic test_masked();
    run_insn('{id: 3'd3, vd: 5'd7, vl: 10'd300, vm: 1'b0});
  endtask

  // Lane 1 withholds grants, so only two beats fit before operands stall
  task automatic test_backpressure();
    int first;
    first     = exp_q.size();
    gnt_block = 2'b10;
    fork
      run_insn('{id: 3'd4, vd: 5'd2, vl: 10'd512, vm: 1'b1});
      begin
        repeat (12) @(negedge clk);
        check_flag(exp_q.size() - first == ResultQueueDepth, 1'b1, "two beats in flight");
        check_flag(operand_ready == '0, 1'b1, "operands stall on full queue");
        #SettleNs;
        gnt_block = '0;
      end
    join
  endtask

  initial begin
    rst_n         = 1'b0;
    pe_req        = '0;
    pe_req_valid  = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = '0;
    gnt_block     = '0;
    lfsr_q        = 16'd16;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_full_unmasked();
    test_short_vl();
    test_masked();
    test_backpressure();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
